// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Major opcodes that fetch cares about.
  typedef enum logic [6:0] {
    OP_OTHER    = 7'b0000000,
    OP_MISC_MEM = 7'b0001111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_t;

  // Low two bits of every 32-bit encoding.
  localparam logic [1:0] op_len_32 = 2'b11;

  localparam logic [1:0] c_quadrant_1 = 2'b01;
  localparam logic [2:0] c_funct3_j = 3'b101;

  function automatic logic is_compressed(input logic [31:0] inst);
    return inst[1:0] != op_len_32;
  endfunction

  // C.J lives in quadrant 1 with funct3 101.
  function automatic logic is_c_j(input logic [31:0] inst);
    return (inst[1:0] == c_quadrant_1) && (inst[15:13] == c_funct3_j);
  endfunction

  function automatic opcode_t decode_opcode(input logic [31:0] inst);
    opcode_t op;
    op = OP_OTHER;
    if (!is_compressed(inst)) begin
      case (inst[6:0])
        OP_JAL:      op = OP_JAL;
        OP_SYSTEM:   op = OP_SYSTEM;
        OP_MISC_MEM: op = OP_MISC_MEM;
        default:     op = OP_OTHER;
      endcase
    end
    return op;
  endfunction

endpackage

// ==== fetch_pkg.sv ====
package fetch_pkg;

  // Widest supported XLEN; narrower cores use the low bits.
  localparam int max_xlen = 64;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    VALID = 2'b01,
    STALL = 2'b10
  } fetch_state_t;

  // Packet handed to decode.
  typedef struct packed {
    logic [max_xlen-1:0] pc;
    logic [max_xlen-1:0] pnpc;
    logic [max_xlen-1:0] inst;
  } fetch_packet_t;

  // Redirect and cache maintenance from commit.
  typedef struct packed {
    logic                flush_pipe;
    logic                fence_i;
    logic [max_xlen-1:0] cpc;
  } commit_bcast_t;

endpackage

// ==== next_pc_predictor.sv ====
`timescale 1ns/1ps

module next_pc_predictor #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] pc,
  input  logic [31:0]     inst,
  output logic [XLEN-1:0] predicted_npc
);

  import rv_isa_pkg::*;

  logic            is_c;
  logic            is_jal;
  logic            is_cj;
  opcode_t         opcode;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_cj;
  logic [XLEN-1:0] offset;

  assign is_c = is_compressed(inst);
  assign opcode = decode_opcode(inst);
  assign is_jal = (opcode == OP_JAL);
  assign is_cj = is_c_j(inst);

  // J-type immediate, bits 20|10:1|11|19:12.
  assign imm_j = {
    {(XLEN-20){inst[31]}},
    inst[19:12],
    inst[20],
    inst[30:21],
    1'b0
  };

  // CJ-format immediate, bits 11|4|9:8|10|6|7|3:1|5.
  assign imm_cj = {
    {(XLEN-11){inst[12]}},
    inst[8],
    inst[10:9],
    inst[6],
    inst[7],
    inst[2],
    inst[11],
    inst[5:3],
    1'b0
  };

  always_comb begin
    if (is_jal) begin
      offset = imm_j;
    end else if (is_cj) begin
      offset = imm_cj;
    end else if (is_c) begin
      offset = XLEN'(2);
    end else begin
      offset = XLEN'(4);
    end
  end

  // Static prediction, taken for direct jumps.
  assign predicted_npc = pc + offset;

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter int              XLEN    = 32,
  parameter logic [XLEN-1:0] PC_INIT = XLEN'(32'h8000_0000)
) (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::commit_bcast_t commit_bcast,
  input  logic [31:0]              imem_inst,
  input  logic                     imem_valid,
  input  logic [XLEN-1:0]          predicted_npc,
  output logic [XLEN-1:0]          fetch_pc,
  output logic                     imem_invalidate,
  output fetch_pkg::fetch_packet_t out_packet,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  fetch_state_t    state;
  logic [XLEN-1:0] held_pc;
  logic [31:0]     held_inst;
  logic [XLEN-1:0] next_fetch_pc;
  opcode_t         held_opcode;
  logic            held_is_sys;
  logic            flush;

  assign flush = commit_bcast.flush_pipe;

  // Serializing instructions wait for commit to redirect.
  assign held_opcode = decode_opcode(held_inst);
  assign held_is_sys = (held_opcode == OP_SYSTEM) || (held_opcode == OP_MISC_MEM);

  assign next_fetch_pc = flush ? commit_bcast.cpc[XLEN-1:0] : predicted_npc;

  assign imem_invalidate = commit_bcast.fence_i;
  assign out_valid = (state == VALID);

  always_comb begin
    out_packet = '0;
    out_packet.pc[XLEN-1:0] = held_pc;
    // fetch_pc already points at the predicted successor.
    out_packet.pnpc[XLEN-1:0] = fetch_pc;
    out_packet.inst[31:0] = held_inst;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      fetch_pc <= PC_INIT;
    end else begin
      unique case (state)
        IDLE: begin
          if (flush) begin
            fetch_pc <= next_fetch_pc;
          end else if (imem_valid) begin
            state <= VALID;
            fetch_pc <= next_fetch_pc;
          end
        end
        VALID: begin
          if (flush) begin
            state <= IDLE;
            fetch_pc <= next_fetch_pc;
          end else if (held_is_sys) begin
            state <= STALL;
          end else if (out_ready) begin
            if (imem_valid) begin
              fetch_pc <= next_fetch_pc;
            end else begin
              state <= IDLE;
            end
          end
        end
        STALL: begin
          if (flush) begin
            state <= IDLE;
            fetch_pc <= next_fetch_pc;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Packet capture, same conditions as the FSM load.
  always_ff @(posedge clock) begin
    if (!flush && imem_valid) begin
      if ((state == IDLE) || ((state == VALID) && !held_is_sys && out_ready)) begin
        held_pc <= fetch_pc;
        held_inst <= imem_inst;
      end
    end
  end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
  parameter int              XLEN    = 32,
  parameter logic [XLEN-1:0] PC_INIT = XLEN'(32'h8000_0000)
) (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::commit_bcast_t commit_bcast,
  output logic [XLEN-1:0]          imem_pc,
  output logic                     imem_invalidate,
  input  logic [31:0]              imem_inst,
  input  logic                     imem_valid,
  output fetch_pkg::fetch_packet_t out_packet,
  output logic                     out_valid,
  input  logic                     out_ready
);

  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] predicted_npc;

  assign imem_pc = fetch_pc;

  // Prediction runs on the word arriving from memory.
  next_pc_predictor #(
    .XLEN(XLEN)
  ) next_pc_predictor_i (
    .pc           (fetch_pc),
    .inst         (imem_inst),
    .predicted_npc(predicted_npc)
  );

  fetch_unit #(
    .XLEN   (XLEN),
    .PC_INIT(PC_INIT)
  ) fetch_unit_i (
    .clock          (clock),
    .reset          (reset),
    .commit_bcast   (commit_bcast),
    .imem_inst      (imem_inst),
    .imem_valid     (imem_valid),
    .predicted_npc  (predicted_npc),
    .fetch_pc       (fetch_pc),
    .imem_invalidate(imem_invalidate),
    .out_packet     (out_packet),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;

  import fetch_pkg::*;

  localparam int          XLEN           = 32;
  localparam logic [31:0] PC_INIT        = 32'h8000_0000;
  localparam int          NUM_PACKETS    = 400;
  localparam int          MEM_WAIT_MAX   = 3;
  localparam int          TIMEOUT_CYCLES = NUM_PACKETS * (MEM_WAIT_MAX + 2) * 2 + 2000;

  logic            clock;
  logic            reset;
  commit_bcast_t   commit_bcast;
  logic [XLEN-1:0] imem_pc;
  logic            imem_invalidate;
  logic [31:0]     imem_inst;
  logic            imem_valid;
  fetch_packet_t   out_packet;
  logic            out_valid;
  logic            out_ready;

  logic [31:0]     rng = 32'h11f6;
  logic [31:0]     mem_addr;
  logic [1:0]      mem_wait;
  logic            stalled;
  logic [2:0]      stall_wait;
  logic            flush_now;
  logic [31:0]     cpc_next;
  logic [31:0]     expect_pc;
  logic            reset_d = 1'b0;
  logic            flush_d = 1'b0;
  logic [31:0]     cpc_d;
  logic            hold_d = 1'b0;
  fetch_packet_t   packet_d;
  logic [31:0]     pc_d;
  int              packets = 0;
  int              cycles = 0;
  int              check_errors = 0;
  int              timeouts = 0;

  fetch_top #(
    .XLEN   (XLEN),
    .PC_INIT(PC_INIT)
  ) fetch_top_i (
    .clock          (clock),
    .reset          (reset),
    .commit_bcast   (commit_bcast),
    .imem_pc        (imem_pc),
    .imem_invalidate(imem_invalidate),
    .imem_inst      (imem_inst),
    .imem_valid     (imem_valid),
    .out_packet     (out_packet),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Instruction stored at a given address.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] h;
    logic [31:0] w;
    h = xorshift32(addr ^ 32'h5bd1_e995);
    h = xorshift32(h + addr);
    w = {h[24:0], 7'b0010011};
    if (h[31:28] >= 4'd6 && h[31:28] <= 4'd9) begin
      w = {h[31:2], h[1], 1'b0};
    end else if (h[31:28] == 4'd10 || h[31:28] == 4'd11) begin
      w = {h[31:7], 7'b1101111};
      w[23] = 1'b1;
    end else if (h[31:28] == 4'd12 || h[31:28] == 4'd13) begin
      w = {h[31:16], 3'b101, h[12:2], 2'b01};
      w[3] = 1'b1;
    end else if (h[31:28] == 4'd15 && h[9]) begin
      w = h[8] ? {h[31:7], 7'b1110011} : {h[31:7], 7'b0001111};
    end
    return w;
  endfunction

  function automatic logic [31:0] predict_npc(input logic [31:0] pc, input logic [31:0] inst);
    logic [20:0] j_off;
    logic [11:0] cj_off;
    logic [31:0] npc;
    j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    cj_off = {inst[12], inst[8], inst[10:9], inst[6], inst[7], inst[2], inst[11], inst[5:3], 1'b0};
    if (inst[1:0] == 2'b11 && inst[6:0] == 7'b1101111) begin
      npc = pc + {{11{j_off[20]}}, j_off};
    end else if (inst[1:0] == 2'b01 && inst[15:13] == 3'b101) begin
      npc = pc + {{20{cj_off[11]}}, cj_off};
    end else if (inst[1:0] != 2'b11) begin
      npc = pc + 32'd2;
    end else begin
      npc = pc + 32'd4;
    end
    return npc;
  endfunction

  function automatic logic is_serializing(input logic [31:0] inst);
    return inst[1:0] == 2'b11 && (inst[6:0] == 7'b1110011 || inst[6:0] == 7'b0001111);
  endfunction

  // Address compare inside the memory.
  assign imem_valid = (mem_addr == imem_pc) && (mem_wait == 2'd0);

  always @(posedge clock) begin
    rng = xorshift32(rng);
    if (imem_pc != mem_addr) begin
      mem_addr <= imem_pc;
      imem_inst <= word_at(imem_pc);
      mem_wait <= rng[1:0];
    end else if (mem_wait != 2'd0) begin
      mem_wait <= mem_wait - 2'd1;
    end
    flush_now = 1'b0;
    cpc_next = PC_INIT + {20'd0, rng[27:17], 1'b0};
    if (reset) begin
      stalled <= 1'b0;
    end else if (commit_bcast.flush_pipe) begin
      stalled <= 1'b0;
    end else if (out_valid && is_serializing(out_packet.inst[31:0])) begin
      stalled <= 1'b1;
      stall_wait <= rng[20:18];
    end else if (stalled) begin
      if (stall_wait == 3'd0) begin
        flush_now = 1'b1;
      end else begin
        stall_wait <= stall_wait - 3'd1;
      end
    end else if (rng[15:10] == 6'd0) begin
      flush_now = 1'b1;
    end
    commit_bcast.flush_pipe <= flush_now && !reset;
    commit_bcast.cpc <= {32'h0, cpc_next};
    commit_bcast.fence_i <= !reset && rng[9:7] == 3'd0;
    // Decode never accepts in a flush cycle.
    out_ready <= !reset && !flush_now && rng[3:2] != 2'd0;
  end

  always @(posedge clock) begin
    reset_d <= reset;
    flush_d <= !reset && commit_bcast.flush_pipe;
    cpc_d <= commit_bcast.cpc[31:0];
    hold_d <= !reset && out_valid && !out_ready && !commit_bcast.flush_pipe;
    packet_d <= out_packet;
    pc_d <= imem_pc;
    cycles <= cycles + 1;
    if (reset) begin
      expect_pc <= PC_INIT;
    end else if (commit_bcast.flush_pipe) begin
      expect_pc <= commit_bcast.cpc[31:0];
    end else if (out_valid && out_ready) begin
      expect_pc <= predict_npc(expect_pc, word_at(expect_pc));
      packets <= packets + 1;
    end
  end

  assert property (@(posedge clock) reset_d |-> !out_valid && imem_pc == PC_INIT)
  else begin
    check_errors++;
    $display("ERROR imem_pc after reset expected %h got %h, out_valid %h",
             PC_INIT, $sampled(imem_pc), $sampled(out_valid));
  end

  assert property (@(posedge clock) disable iff (reset)
    out_valid && out_ready |-> out_packet.inst[31:0] == word_at(out_packet.pc[31:0]))
  else begin
    check_errors++;
    $display("ERROR out_packet.inst expected %h got %h",
             word_at($sampled(out_packet.pc[31:0])), $sampled(out_packet.inst[31:0]));
  end

  assert property (@(posedge clock) disable iff (reset)
    out_valid && out_ready |->
      out_packet.pnpc[31:0] == predict_npc(out_packet.pc[31:0], out_packet.inst[31:0]))
  else begin
    check_errors++;
    $display("ERROR out_packet.pnpc expected %h got %h",
             predict_npc($sampled(out_packet.pc[31:0]), $sampled(out_packet.inst[31:0])),
             $sampled(out_packet.pnpc[31:0]));
  end

  assert property (@(posedge clock) disable iff (reset)
    out_valid && out_ready |-> out_packet.pc[31:0] == expect_pc)
  else begin
    check_errors++;
    $display("ERROR out_packet.pc expected %h got %h",
             $sampled(expect_pc), $sampled(out_packet.pc[31:0]));
  end

  assert property (@(posedge clock) disable iff (reset)
    hold_d |-> out_packet == packet_d && imem_pc == pc_d)
  else begin
    check_errors++;
    $display("ERROR held out_packet expected %h got %h, imem_pc expected %h got %h",
             $sampled(packet_d), $sampled(out_packet), $sampled(pc_d), $sampled(imem_pc));
  end

  assert property (@(posedge clock) disable iff (reset) stalled |-> !(out_valid && out_ready))
  else begin
    check_errors++;
    $display("Packet at pc %h was handed to decode while fetch should be stalled",
             $sampled(out_packet.pc[31:0]));
  end

  assert property (@(posedge clock) disable iff (reset) flush_d |-> imem_pc == cpc_d)
  else begin
    check_errors++;
    $display("ERROR imem_pc after flush expected %h got %h", $sampled(cpc_d), $sampled(imem_pc));
  end

  assert property (@(posedge clock) imem_invalidate == commit_bcast.fence_i)
  else begin
    check_errors++;
    $display("ERROR imem_invalidate expected %h got %h",
             $sampled(commit_bcast.fence_i), $sampled(imem_invalidate));
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    commit_bcast = '0;
    imem_inst = 32'h0;
    out_ready = 1'b0;
    mem_addr = ~PC_INIT;
    mem_wait = 2'd0;
    stalled = 1'b0;
    stall_wait = 3'd0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    while (packets < NUM_PACKETS && cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
    end
    if (packets < NUM_PACKETS) begin
      timeouts++;
      $display("Timed out after %0d cycles with only %0d of %0d packets received",
               cycles, packets, NUM_PACKETS);
    end
    $display("Summary: %0d packets, %0d check errors, %0d timeouts",
             packets, check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rv_isa_pkg.sv
fetch_pkg.sv
next_pc_predictor.sv
fetch_unit.sv
fetch_top.sv
tb_fetch_top.sv

// ==== Makefile ====
# Verilator simulation of the fetch stage.

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= TEST PASSED

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
	  echo "Simulation result: pass"; \
	else \
	  echo "Simulation result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
